//--- filelist.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/pipe_control.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/cpu_core.sv
test/cpu_core_props.sv
test/cpu_core_tb.sv

//--- rtl/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_WORD_W   16
`define CPU_REG_N    4
`define CPU_RESET_PC 16'h0000

// opcode field in bits 15:12
`define OP_BNE   4'd0
`define OP_BEQ   4'd1
`define OP_ADI   4'd4
`define OP_LHI   4'd6
`define OP_LWD   4'd7
`define OP_SWD   4'd8
`define OP_JMP   4'd9
`define OP_RTYPE 4'd15

// func field of R-type in bits 5:0
`define FN_ADD   6'd0
`define FN_SUB   6'd1
`define FN_AND   6'd2
`define FN_ORR   6'd3
`define FN_WWD   6'd28
`define FN_HLT   6'd29

// next pc select
`define PC_SEL_SEQ 2'd0
`define PC_SEL_BR  2'd1
`define PC_SEL_JMP 2'd2

`endif

//--- rtl/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire cpu_pkg::word_t imem_data,
    input  wire cpu_pkg::word_t wb_dat_i,
    input  wire                 wb_ack,
    output cpu_pkg::word_t      imem_addr,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output cpu_pkg::word_t      wb_adr,
    output cpu_pkg::word_t      wb_dat_o,
    output cpu_pkg::word_t      output_port,
    output logic                output_valid,
    output cpu_pkg::word_t      num_inst,
    output logic                is_halted
);

    cpu_pkg::word_t    if_id_pc;
    cpu_pkg::word_t    if_id_instr;
    logic              if_id_valid;
    cpu_pkg::ctrl_t    ctrl_id;
    cpu_pkg::reg_idx_t dst_id;
    logic              stall_id;
    logic              freeze;
    logic [1:0]        pc_sel;
    logic              branch_taken;
    cpu_pkg::word_t    branch_target;
    cpu_pkg::word_t    jump_target;
    cpu_pkg::id_ex_t   id_ex;
    cpu_pkg::ex_mem_t  ex_mem;
    logic              mem_busy;
    cpu_pkg::reg_idx_t wb_dst;
    cpu_pkg::word_t    wb_val;
    logic              wb_en;

    pipe_control u_pipe_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (if_id_instr),
        .instr_valid  (if_id_valid),
        .id_ex_ctrl   (id_ex.ctrl),
        .id_ex_dst    (id_ex.dst),
        .ex_mem_ctrl  (ex_mem.ctrl),
        .ex_mem_dst   (ex_mem.dst),
        .branch_taken (branch_taken),
        .mem_busy     (mem_busy),
        .halted       (is_halted),
        .ctrl_id      (ctrl_id),
        .dst_id       (dst_id),
        .stall_id     (stall_id),
        .freeze       (freeze),
        .pc_sel       (pc_sel)
    );

    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_data     (imem_data),
        .stall_id      (stall_id),
        .freeze        (freeze),
        .pc_sel        (pc_sel),
        .branch_target (branch_target),
        .jump_target   (jump_target),
        .imem_addr     (imem_addr),
        .if_id_pc      (if_id_pc),
        .if_id_instr   (if_id_instr),
        .if_id_valid   (if_id_valid)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .if_id_pc      (if_id_pc),
        .if_id_instr   (if_id_instr),
        .ctrl_id       (ctrl_id),
        .dst_id        (dst_id),
        .stall_id      (stall_id),
        .freeze        (freeze),
        .wb_dst        (wb_dst),
        .wb_val        (wb_val),
        .wb_en         (wb_en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .jump_target   (jump_target),
        .id_ex         (id_ex)
    );

    execute_stage u_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .id_ex  (id_ex),
        .freeze (freeze),
        .ex_mem (ex_mem)
    );

    mem_stage u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_mem       (ex_mem),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_o     (wb_dat_o),
        .mem_busy     (mem_busy),
        .wb_dst       (wb_dst),
        .wb_val       (wb_val),
        .wb_en        (wb_en),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

endmodule

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0]        word_t;
    typedef logic [$clog2(`CPU_REG_N)-1:0] reg_idx_t;
    typedef logic [3:0]                    opcode_t;
    typedef logic [5:0]                    func_t;

    // first four follow the R-type func codes
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_ORR = 3'd3,
        ALU_LHI = 3'd4
    } alu_op_e;

    typedef enum logic {
        WB_IDLE,
        WB_WAIT
    } wb_state_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    mem_to_reg;
        logic    is_wwd;
        logic    is_hlt;
        logic    valid;       // 0 for a bubble
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;
        reg_idx_t dst;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_res;
        word_t    store_val;
        word_t    rs_val;
        reg_idx_t dst;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    wb_val;
        word_t    rs_val;
        reg_idx_t dst;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module decode_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire cpu_pkg::word_t    if_id_pc,
    input  wire cpu_pkg::word_t    if_id_instr,
    input  wire cpu_pkg::ctrl_t    ctrl_id,
    input  wire cpu_pkg::reg_idx_t dst_id,
    input  wire                    stall_id,
    input  wire                    freeze,
    input  wire cpu_pkg::reg_idx_t wb_dst,
    input  wire cpu_pkg::word_t    wb_val,
    input  wire                    wb_en,
    output logic                   branch_taken,
    output cpu_pkg::word_t         branch_target,
    output cpu_pkg::word_t         jump_target,
    output cpu_pkg::id_ex_t        id_ex
);

    cpu_pkg::opcode_t op;
    cpu_pkg::word_t   imm;
    cpu_pkg::word_t   rs_val;
    cpu_pkg::word_t   rt_val;

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs     (if_id_instr[11:10]),
        .rt     (if_id_instr[9:8]),
        .wr_idx (wb_dst),
        .wr_val (wb_val),
        .wr_en  (wb_en),
        .rs_val (rs_val),
        .rt_val (rt_val)
    );

    assign op  = if_id_instr[15:12];
    assign imm = {{(`CPU_WORD_W-8){if_id_instr[7]}}, if_id_instr[7:0]};

    assign branch_target = if_id_pc + 1'b1 + imm;
    assign jump_target   = {if_id_pc[15:12], if_id_instr[11:0]};

    // raw condition that control qualifies with valid and stall
    always_comb begin
        case (op)
            `OP_BEQ: branch_taken = (rs_val == rt_val);
            `OP_BNE: branch_taken = (rs_val != rt_val);
            default: branch_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.ctrl <= '0;
        end else if (!freeze) begin
            if (stall_id)
                id_ex.ctrl <= '0;
            else
                id_ex.ctrl <= ctrl_id;
            id_ex.rs_val <= rs_val;
            id_ex.rt_val <= rt_val;
            id_ex.imm    <= imm;
            id_ex.dst    <= dst_id;
        end
    end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire cpu_pkg::id_ex_t  id_ex,
    input  wire                   freeze,
    output cpu_pkg::ex_mem_t      ex_mem
);

    cpu_pkg::word_t opnd_b;
    cpu_pkg::word_t alu_res;

    assign opnd_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rt_val;

    // LWD/SWD address comes out of ALU_ADD
    always_comb begin
        case (id_ex.ctrl.alu_op)
            cpu_pkg::ALU_ADD: alu_res = id_ex.rs_val + opnd_b;
            cpu_pkg::ALU_SUB: alu_res = id_ex.rs_val - opnd_b;
            cpu_pkg::ALU_AND: alu_res = id_ex.rs_val & opnd_b;
            cpu_pkg::ALU_ORR: alu_res = id_ex.rs_val | opnd_b;
            cpu_pkg::ALU_LHI: alu_res = opnd_b << 8;
            default:          alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.ctrl <= '0;
        end else if (!freeze) begin
            ex_mem.ctrl      <= id_ex.ctrl;
            ex_mem.alu_res   <= alu_res;
            ex_mem.store_val <= id_ex.rt_val;
            ex_mem.rs_val    <= id_ex.rs_val;
            ex_mem.dst       <= id_ex.dst;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module fetch_stage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire cpu_pkg::word_t imem_data,
    input  wire                 stall_id,
    input  wire                 freeze,
    input  wire [1:0]           pc_sel,
    input  wire cpu_pkg::word_t branch_target,
    input  wire cpu_pkg::word_t jump_target,
    output cpu_pkg::word_t      imem_addr,
    output cpu_pkg::word_t      if_id_pc,
    output cpu_pkg::word_t      if_id_instr,
    output logic                if_id_valid
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_next;
    logic           redirect;

    assign imem_addr = pc;
    assign redirect  = (pc_sel != `PC_SEL_SEQ);

    always_comb begin
        case (pc_sel)
            `PC_SEL_BR:  pc_next = branch_target;
            `PC_SEL_JMP: pc_next = jump_target;
            default:     pc_next = pc + 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= `CPU_RESET_PC;
            if_id_valid <= 1'b0;
        end else if (!freeze) begin
            if (redirect) begin
                pc          <= pc_next;
                if_id_valid <= 1'b0;    // wrong-path fetch
            end else if (!stall_id) begin
                pc          <= pc_next;
                if_id_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && !stall_id && !redirect) begin
            if_id_pc    <= pc;
            if_id_instr <= imem_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire cpu_pkg::ex_mem_t ex_mem,
    input  wire cpu_pkg::word_t   wb_dat_i,
    input  wire                   wb_ack,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output cpu_pkg::word_t        wb_adr,
    output cpu_pkg::word_t        wb_dat_o,
    output logic                  mem_busy,
    output cpu_pkg::reg_idx_t     wb_dst,
    output cpu_pkg::word_t        wb_val,
    output logic                  wb_en,
    output cpu_pkg::word_t        output_port,
    output logic                  output_valid,
    output cpu_pkg::word_t        num_inst,
    output logic                  is_halted
);

    cpu_pkg::wb_state_e state;
    cpu_pkg::mem_wb_t   mem_wb;
    logic               mem_req;
    logic               load_wb;

    assign mem_req = ex_mem.ctrl.valid && !is_halted
                  && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);

    // low in the ack cycle so the pipe moves on
    assign mem_busy = (state == cpu_pkg::WB_IDLE) ? mem_req : !wb_ack;
    assign load_wb  = !is_halted && !mem_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= cpu_pkg::WB_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::WB_IDLE: begin
                    if (mem_req) begin
                        state  <= cpu_pkg::WB_WAIT;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end
                end
                cpu_pkg::WB_WAIT: begin
                    if (wb_ack) begin
                        state  <= cpu_pkg::WB_IDLE;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                    end
                end
                default: state <= cpu_pkg::WB_IDLE;
            endcase
        end
    end

    // held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::WB_IDLE && mem_req) begin
            wb_we    <= ex_mem.ctrl.mem_write;
            wb_adr   <= ex_mem.alu_res;
            wb_dat_o <= ex_mem.store_val;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.ctrl <= '0;
            num_inst    <= '0;
            is_halted   <= 1'b0;
        end else begin
            if (load_wb)
                mem_wb.ctrl <= ex_mem.ctrl;
            else
                mem_wb.ctrl <= '0;      // bubble while waiting
            if (load_wb && ex_mem.ctrl.valid) begin
                num_inst <= num_inst + 1'b1;
                if (ex_mem.ctrl.is_hlt)
                    is_halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_wb) begin
            mem_wb.wb_val <= ex_mem.ctrl.mem_to_reg ? wb_dat_i : ex_mem.alu_res;
            mem_wb.rs_val <= ex_mem.rs_val;
            mem_wb.dst    <= ex_mem.dst;
        end
    end

    assign wb_en  = mem_wb.ctrl.valid && mem_wb.ctrl.reg_write;
    assign wb_dst = mem_wb.dst;
    assign wb_val = mem_wb.wb_val;

    assign output_port  = mem_wb.rs_val;
    assign output_valid = mem_wb.ctrl.valid && mem_wb.ctrl.is_wwd;

endmodule

`default_nettype wire

//--- rtl/pipe_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module pipe_control (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire cpu_pkg::word_t    instr,
    input  wire                    instr_valid,
    input  wire cpu_pkg::ctrl_t    id_ex_ctrl,
    input  wire cpu_pkg::reg_idx_t id_ex_dst,
    input  wire cpu_pkg::ctrl_t    ex_mem_ctrl,
    input  wire cpu_pkg::reg_idx_t ex_mem_dst,
    input  wire                    branch_taken,
    input  wire                    mem_busy,
    input  wire                    halted,
    output cpu_pkg::ctrl_t         ctrl_id,
    output cpu_pkg::reg_idx_t      dst_id,
    output logic                   stall_id,
    output logic                   freeze,
    output logic [1:0]             pc_sel
);

    cpu_pkg::opcode_t  op;
    cpu_pkg::func_t    func;
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    logic              use_rs;
    logic              use_rt;
    logic              legal;
    logic              is_jmp;
    logic              rs_busy;
    logic              rt_busy;
    logic              hlt_seen;    // HLT has left decode

    assign op   = instr[15:12];
    assign func = instr[5:0];
    assign rs   = instr[11:10];
    assign rt   = instr[9:8];

    always_comb begin
        ctrl_id        = '0;
        ctrl_id.alu_op = cpu_pkg::ALU_ADD;
        dst_id         = rt;
        use_rs         = 1'b1;
        use_rt         = 1'b0;
        legal          = 1'b1;
        is_jmp         = 1'b0;
        case (op)
            `OP_RTYPE: begin
                dst_id = instr[7:6];
                case (func)
                    `FN_ADD, `FN_SUB, `FN_AND, `FN_ORR: begin
                        ctrl_id.alu_op    = cpu_pkg::alu_op_e'(func[2:0]);
                        ctrl_id.reg_write = 1'b1;
                        use_rt            = 1'b1;
                    end
                    `FN_WWD: ctrl_id.is_wwd = 1'b1;
                    `FN_HLT: begin
                        ctrl_id.is_hlt = 1'b1;
                        use_rs         = 1'b0;
                    end
                    default: legal = 1'b0;
                endcase
            end
            `OP_ADI: begin
                ctrl_id.alu_src_imm = 1'b1;
                ctrl_id.reg_write   = 1'b1;
            end
            `OP_LHI: begin
                ctrl_id.alu_op      = cpu_pkg::ALU_LHI;
                ctrl_id.alu_src_imm = 1'b1;
                ctrl_id.reg_write   = 1'b1;
                use_rs              = 1'b0;
            end
            `OP_LWD: begin
                ctrl_id.alu_src_imm = 1'b1;
                ctrl_id.mem_read    = 1'b1;
                ctrl_id.reg_write   = 1'b1;
                ctrl_id.mem_to_reg  = 1'b1;
            end
            `OP_SWD: begin
                ctrl_id.alu_src_imm = 1'b1;
                ctrl_id.mem_write   = 1'b1;
                use_rt              = 1'b1;
            end
            `OP_BEQ, `OP_BNE: use_rt = 1'b1;
            `OP_JMP: begin
                is_jmp = 1'b1;
                use_rs = 1'b0;
            end
            default: legal = 1'b0;
        endcase
        ctrl_id.valid = instr_valid && legal && !hlt_seen;
    end

    // no forwarding so wait until the writer sits in MEM/WB
    assign rs_busy = (id_ex_ctrl.valid && id_ex_ctrl.reg_write && id_ex_dst == rs)
                  || (ex_mem_ctrl.valid && ex_mem_ctrl.reg_write && ex_mem_dst == rs);
    assign rt_busy = (id_ex_ctrl.valid && id_ex_ctrl.reg_write && id_ex_dst == rt)
                  || (ex_mem_ctrl.valid && ex_mem_ctrl.reg_write && ex_mem_dst == rt);
    assign stall_id = ctrl_id.valid && ((use_rs && rs_busy) || (use_rt && rt_busy));

    assign freeze = mem_busy || halted;

    always_comb begin
        pc_sel = `PC_SEL_SEQ;
        if (ctrl_id.valid && !stall_id) begin
            if (is_jmp)
                pc_sel = `PC_SEL_JMP;
            else if (branch_taken)
                pc_sel = `PC_SEL_BR;
        end
    end

    // anything fetched behind HLT drains as bubbles
    always_ff @(posedge clk) begin
        if (!rst_n)
            hlt_seen <= 1'b0;
        else if (ctrl_id.valid && ctrl_id.is_hlt && !freeze)
            hlt_seen <= 1'b1;
    end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module reg_file (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire cpu_pkg::reg_idx_t rs,
    input  wire cpu_pkg::reg_idx_t rt,
    input  wire cpu_pkg::reg_idx_t wr_idx,
    input  wire cpu_pkg::word_t    wr_val,
    input  wire                    wr_en,
    output cpu_pkg::word_t         rs_val,
    output cpu_pkg::word_t         rt_val
);

    cpu_pkg::word_t regs [`CPU_REG_N];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_N; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_idx] <= wr_val;
        end
    end

    // writeback in this cycle is visible to decode
    assign rs_val = (wr_en && wr_idx == rs) ? wr_val : regs[rs];
    assign rt_val = (wr_en && wr_idx == rt) ? wr_val : regs[rt];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f filelist.f --top-module cpu_core_tb -o cpu_core_sim

./obj_dir/cpu_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST OK" sim.log; then
    exit 0
fi
exit 1

//--- test/cpu_core_cases.txt
# P <instr hex>, O <expected WWD hex>, N <retired count decimal>, E ends a case
# case 1 alu, immediates, raw stalls
P 4105
P 42FD
P F6C0
P FC1C
P F6C1
P FC1C
P 6112
P 4234
P F6C3
P FC1C
P F6C2
P FC1C
P F01D
O 0002
O 0008
O 1234
O 0000
N 13
E
# case 2 reset state, store/load, load-use
P F41C
P 61AB
P 453C
P 4210
P 8902
P 7B02
P FC1C
P 83FF
P 70FF
P F241
P F41C
P F01D
O 0000
O AB3C
O AB2C
N 12
E
# case 3 branches and jump
P 4101
P 4201
P 1602
P F41C
P F01D
P 0601
P 4307
P FC1C
P 0701
P F41C
P 900D
P FC1C
P F01D
P 1701
P F81C
P F01D
O 0007
O 0001
N 11
E

//--- test/cpu_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_props (
    input wire        clk,
    input wire        rst_n,
    input wire        wb_cyc,
    input wire        wb_stb,
    input wire        wb_we,
    input wire        wb_ack,
    input wire [15:0] wb_adr,
    input wire [15:0] wb_dat_o,
    input wire        output_valid,
    input wire        is_halted,
    input wire [15:0] num_inst
);

    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else $error("wb_stb without wb_cyc");

    // request held until ack
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat_o) && $stable(wb_we))
        else $error("wishbone request changed while waiting");

    no_out_halted: assert property (@(posedge clk) disable iff (!rst_n)
        is_halted |-> !output_valid)
        else $error("output after halt");

    reset_idle: assert property (@(posedge clk) $rose(rst_n)
        |-> !wb_cyc && !wb_stb && !output_valid && !is_halted && num_inst == 0)
        else $error("outputs active after reset");

endmodule

bind cpu_core cpu_core_props props_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_ack       (wb_ack),
    .wb_adr       (wb_adr),
    .wb_dat_o     (wb_dat_o),
    .output_valid (output_valid),
    .is_halted    (is_halted),
    .num_inst     (num_inst)
);

`default_nettype wire

//--- test/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

    logic        clk;
    logic        rst_n;
    logic [15:0] imem_data;
    logic [15:0] wb_dat_i;
    logic        wb_ack;
    logic [15:0] imem_addr;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [15:0] wb_dat_o;
    logic [15:0] output_port;
    logic        output_valid;
    logic [15:0] num_inst;
    logic        is_halted;

    logic [15:0] imem [256];
    logic [15:0] dmem [256];
    logic [15:0] exp_q[$];
    logic [15:0] exp_word;
    int          exp_n;
    int          fd;
    int          total_words;
    int          wd_cycles;
    bit          running;
    logic [31:0] rng;
    int          waits;
    bit          active;

    cpu_core dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_data    (imem_data),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .imem_addr    (imem_addr),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_o     (wb_dat_o),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    assign imem_data = imem[imem_addr[7:0]];   // combinational fetch

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "stopping after error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            fail_run();
        end
    endtask

    // Wishbone slave with 0-3 wait states before ack
    always @(posedge clk) begin
        #1;
        if (!rst_n) begin
            wb_ack = 1'b0;
            active = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
            active = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!active) begin
                active = 1'b1;
                rng    = xorshift32(rng);
                waits  = rng % 4;
            end
            if (waits == 0) begin
                if (wb_we)
                    dmem[wb_adr[7:0]] = wb_dat_o;
                else
                    wb_dat_i = dmem[wb_adr[7:0]];
                wb_ack = 1'b1;
            end else begin
                waits--;
            end
        end
    end

    always @(negedge clk) begin
        if (running && rst_n && output_valid) begin
            if (exp_q.size() == 0) begin
                $display("output_valid seen with no expected value left");
                fail_run();
            end else begin
                exp_word = exp_q.pop_front();
                check("output_port", output_port, exp_word);
            end
        end
    end

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired, the program did not halt in time");
        fail_run();
    end

    task automatic skip_line();
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1)
            ch = $fgetc(fd);
    endtask

    // loads one case into the memories and clears got at end of file
    task automatic read_case(output bit got, output int words);
        byte         tag;
        int          n;
        logic [15:0] val;
        got   = 0;
        words = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        exp_q.delete();
        forever begin
            n = $fscanf(fd, " %c", tag);
            if (n != 1)
                return;
            if (tag == "#") begin
                skip_line();
            end else if (tag == "P") begin
                n = $fscanf(fd, "%h", val);
                imem[words] = val;
                words++;
            end else if (tag == "O") begin
                n = $fscanf(fd, "%h", val);
                exp_q.push_back(val);
            end else if (tag == "N") begin
                n = $fscanf(fd, "%d", exp_n);
            end else if (tag == "E") begin
                got = 1;
                return;
            end
        end
    endtask

    task automatic run_case();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        running = 1'b1;
        while (!is_halted)
            @(negedge clk);
        check("num_inst", num_inst, exp_n);
        check("outputs_left", exp_q.size(), 0);
        repeat (4) @(negedge clk);
        check("is_halted", is_halted, 1'b1);
        check("num_inst", num_inst, exp_n);
        running = 1'b0;
    endtask

    initial begin
        bit got;
        int words;
        rst_n       = 1'b0;
        wb_ack      = 1'b0;
        wb_dat_i    = '0;
        running     = 1'b0;
        active      = 1'b0;
        waits       = 0;
        rng         = 32'h0498_d553;
        wd_cycles   = 0;
        total_words = 0;
        fd = $fopen("test/cpu_core_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file");
            fail_run();
        end
        got = 1;
        while (got) begin
            read_case(got, words);
            total_words += words;
        end
        $fclose(fd);
        wd_cycles = 64 * total_words;    // arms the watchdog
        fd = $fopen("test/cpu_core_cases.txt", "r");
        read_case(got, words);
        while (got) begin
            run_case();
            read_case(got, words);
        end
        $fclose(fd);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
